// ==== Makefile ====
VERILATOR	= verilator
VFLAGS		= --binary --timing --assert -j 0
TOP			= dmem_tb
FILELIST	= src.f
BUILD_DIR	= obj_dir
LOG			= sim.log
PASS_MSG	= All tests passed!

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/dmem_agu.sv ====
// Strided address generator for one channel.
// Base, stride and length are captured on start; later descriptor
// writes do not affect a running access. The address wraps at the
// end of the memory. Zero lengths and starts while running are
// dropped by the decoder before they reach this block.

`timescale 1ns/100ps

module dmem_agu
	import dmem_pkg::*;
(
	input	logic		clock,
	input	logic		reset,
	dmem_desc_if.agu	desc,
	dmem_access_if.agu	acc
);

	agu_state_t	state;
	address_t	addr_q;			// Current address
	stride_t	stride_q;		// Captured stride
	length_t	remain_q;		// Words left, including current
	logic		running;
	logic		step;			// Address consumed this cycle
	logic		last_word;

	assign running		= (state == AGU_RUN);
	assign step			= running & ~acc.hold;
	assign last_word	= running & (remain_q == length_t'(1));

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state	<= AGU_IDLE;
		end else begin
			case (state)
				AGU_IDLE: begin
					if (desc.start) begin
						state	<= AGU_RUN;
					end
				end
				AGU_RUN: begin
					if (step && last_word) begin
						state	<= AGU_IDLE;	// Busy drops with the last access
					end
				end
				default: state	<= AGU_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Address and count
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			addr_q		<= '0;
			stride_q	<= '0;
			remain_q	<= '0;
		end else if (desc.start) begin
			addr_q		<= desc.base;
			stride_q	<= desc.stride;
			remain_q	<= desc.length;
		end else if (step) begin
			addr_q		<= addr_q + stride_q;	// Wraps modulo depth
			remain_q	<= remain_q - length_t'(1);
		end
	end

	assign desc.busy	= running;

	assign acc.en		= step;
	assign acc.addr		= addr_q;
	assign acc.last		= last_word;

endmodule

// ==== rtl/dmem_bank.sv ====
// Word memory with one store and one load access per cycle.
// A load and store to the same address in one cycle returns the old
// word. The load output is a single register slot; it refills in the
// cycle it is emptied, so ld_ready held high gives one word per cycle.
// Memory contents are undefined after reset.

`timescale 1ns/100ps

`include "dmem_defines.svh"

module dmem_bank
	import dmem_pkg::*;
(
	input	logic			clock,
	input	logic			reset,
	dmem_access_if.bank		st_acc,
	dmem_access_if.bank		ld_acc,
	input	logic			st_valid,
	input	data_t			st_data,
	input	logic			ld_ready,
	output	logic			st_ready,
	output	logic			ld_valid,
	output	data_t			ld_data,
	input	logic			st_busy
);

	data_t	mem [`DMEM_DEPTH];
	data_t	ld_data_q;			// Output slot
	logic	ld_valid_q;

	//////////////////////////////////////////////////
	// Store side
	//////////////////////////////////////////////////

	assign st_ready		= st_busy;
	assign st_acc.hold	= ~st_valid;	// Generator waits for data

	always_ff @(posedge clock) begin
		if (st_acc.en) begin
			mem[st_acc.addr]	<= st_data;
		end
	end

	//////////////////////////////////////////////////
	// Load side
	//////////////////////////////////////////////////

	// Freeze while the slot is full and not taken
	assign ld_acc.hold	= ld_valid_q & ~ld_ready;

	always_ff @(posedge clock) begin
		if (ld_acc.en) begin
			ld_data_q	<= mem[ld_acc.addr];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_valid_q	<= 1'b0;
		end else if (ld_acc.en) begin
			ld_valid_q	<= 1'b1;
		end else if (ld_ready) begin
			ld_valid_q	<= 1'b0;	// Slot drained, nothing new
		end
	end

	assign ld_valid	= ld_valid_q;
	assign ld_data	= ld_data_q;

endmodule

// ==== rtl/dmem_cfg_decode.sv ====
// APB register file for the two access descriptors.
// Zero wait states; pready is tied high. Only misaligned offsets are
// unmapped and raise pslverr. Writes to the status register are ignored.
// A start request while the channel is busy, or with length zero,
// is dropped. The start pulse comes one cycle after the control write.

`timescale 1ns/100ps

`include "dmem_defines.svh"

module dmem_cfg_decode
	import dmem_pkg::*;
(
	input	logic							clock,
	input	logic							reset,
	input	logic							psel,
	input	logic							penable,
	input	logic							pwrite,
	input	logic [`DMEM_APB_ADDR_WIDTH-1:0]	paddr,
	input	data_t							pwdata,
	output	data_t							prdata,
	output	logic							pready,
	output	logic							pslverr,
	dmem_desc_if.cfg						st_desc,
	dmem_desc_if.cfg						ld_desc
);

	// Word index of each register
	localparam logic [2:0] REG_ST_BASE		= 3'd0;
	localparam logic [2:0] REG_ST_LENGTH	= 3'd1;
	localparam logic [2:0] REG_ST_STRIDE	= 3'd2;
	localparam logic [2:0] REG_LD_BASE		= 3'd3;
	localparam logic [2:0] REG_LD_LENGTH	= 3'd4;
	localparam logic [2:0] REG_LD_STRIDE	= 3'd5;
	localparam logic [2:0] REG_CONTROL		= 3'd6;
	localparam logic [2:0] REG_STATUS		= 3'd7;

	logic		access;			// APB access phase
	logic		mapped;			// Offset is word aligned
	logic		wr_en;
	logic		ctrl_wr;
	logic [2:0]	reg_index;

	address_t	st_base;
	length_t	st_length;
	stride_t	st_stride;
	address_t	ld_base;
	length_t	ld_length;
	stride_t	ld_stride;
	logic		st_start;
	logic		ld_start;

	assign access		= psel & penable;
	assign reg_index	= paddr[4:2];
	assign mapped		= (paddr[1:0] == 2'b00);
	assign wr_en		= access & pwrite & mapped;
	assign ctrl_wr		= wr_en & (reg_index == REG_CONTROL);

	assign pready		= 1'b1;
	assign pslverr		= access & ~mapped;

	//////////////////////////////////////////////////
	// Descriptor registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			st_base		<= '0;
			st_length	<= '0;
			st_stride	<= '0;
			ld_base		<= '0;
			ld_length	<= '0;
			ld_stride	<= '0;
		end else if (wr_en) begin
			case (reg_index)
				REG_ST_BASE:	st_base		<= pwdata[`DMEM_ADDR_WIDTH-1:0];
				REG_ST_LENGTH:	st_length	<= pwdata[`DMEM_ADDR_WIDTH-1:0];
				REG_ST_STRIDE:	st_stride	<= pwdata[`DMEM_ADDR_WIDTH-1:0];
				REG_LD_BASE:	ld_base		<= pwdata[`DMEM_ADDR_WIDTH-1:0];
				REG_LD_LENGTH:	ld_length	<= pwdata[`DMEM_ADDR_WIDTH-1:0];
				REG_LD_STRIDE:	ld_stride	<= pwdata[`DMEM_ADDR_WIDTH-1:0];
				default:		;			// Control and status hold no data
			endcase
		end
	end

	// Start pulses, gated by busy and a non-zero length
	always_ff @(posedge clock) begin
		if (reset) begin
			st_start	<= 1'b0;
			ld_start	<= 1'b0;
		end else begin
			st_start	<= ctrl_wr & pwdata[0] & ~st_desc.busy & (st_length != '0);
			ld_start	<= ctrl_wr & pwdata[1] & ~ld_desc.busy & (ld_length != '0);
		end
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	always_comb begin
		case (reg_index)
			REG_ST_BASE:	prdata = data_t'(st_base);
			REG_ST_LENGTH:	prdata = data_t'(st_length);
			REG_ST_STRIDE:	prdata = data_t'(st_stride);
			REG_LD_BASE:	prdata = data_t'(ld_base);
			REG_LD_LENGTH:	prdata = data_t'(ld_length);
			REG_LD_STRIDE:	prdata = data_t'(ld_stride);
			REG_STATUS:		prdata = data_t'({ld_desc.busy, st_desc.busy});
			default:		prdata = '0;	// Control is write only
		endcase
	end

	assign st_desc.start	= st_start;
	assign st_desc.base		= st_base;
	assign st_desc.length	= st_length;
	assign st_desc.stride	= st_stride;

	assign ld_desc.start	= ld_start;
	assign ld_desc.base		= ld_base;
	assign ld_desc.length	= ld_length;
	assign ld_desc.stride	= ld_stride;

endmodule

// ==== rtl/dmem_defines.svh ====
// Global sizes for the strided data memory.
// The word address width must cover the depth exactly, so address
// arithmetic wraps at the end of the array without extra logic.
// The APB address is a byte address over eight 32-bit registers.

`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

//////////////////////////////////////////////////
// Memory geometry
//////////////////////////////////////////////////

`define DMEM_ADDR_WIDTH		8		// Word address bits
`define DMEM_DATA_WIDTH		32		// Bits per word
`define DMEM_DEPTH			256		// Words, equals 2**DMEM_ADDR_WIDTH

//////////////////////////////////////////////////
// Configuration port
//////////////////////////////////////////////////

`define DMEM_APB_ADDR_WIDTH	5		// Byte offsets 0x00..0x1F

`endif

// ==== rtl/dmem_if.sv ====
// Per-channel links inside the data memory.
// The descriptor link carries the programmed access and busy back to
// the decoder. The access link carries one address per cycle from an
// address generator to the bank, with hold as back-pressure.

`timescale 1ns/100ps

//////////////////////////////////////////////////
// Descriptor: decoder to address generator
//////////////////////////////////////////////////

interface dmem_desc_if
	import dmem_pkg::*;
();
	logic		start;		// One-cycle start pulse
	address_t	base;		// First word address
	length_t	length;		// Words to access
	stride_t	stride;		// Address increment
	logic		busy;		// Channel running

	modport cfg (output start, base, length, stride, input busy);
	modport agu (input start, base, length, stride, output busy);
endinterface

//////////////////////////////////////////////////
// Access: address generator to bank
//////////////////////////////////////////////////

interface dmem_access_if
	import dmem_pkg::*;
();
	logic		en;			// Access addr this cycle
	address_t	addr;		// Current word address
	logic		last;		// Final word of descriptor
	logic		hold;		// Stream not ready, freeze

	modport agu (output en, addr, last, input hold);
	modport bank (input en, addr, last, output hold);
endinterface

// ==== rtl/dmem_pkg.sv ====
// Types shared by the strided data memory.
// Stride and length share the address width, so a stride is added
// modulo the memory depth and a length of zero means no access.

`include "dmem_defines.svh"

package dmem_pkg;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	typedef logic [`DMEM_ADDR_WIDTH-1:0]	address_t;	// Word address
	typedef logic [`DMEM_ADDR_WIDTH-1:0]	stride_t;	// Unsigned increment
	typedef logic [`DMEM_ADDR_WIDTH-1:0]	length_t;	// Word count
	typedef logic [`DMEM_DATA_WIDTH-1:0]	data_t;		// Memory word

	//////////////////////////////////////////////////
	// Address generator state
	//////////////////////////////////////////////////

	typedef enum logic {
		AGU_IDLE,	// Waiting for start
		AGU_RUN		// Walking the descriptor
	} agu_state_t;

endpackage

// ==== rtl/dmem_top.sv ====
// Strided data memory, top level.
// APB carries configuration and status only; data moves on the
// store and load valid/ready streams. Each channel runs one
// descriptor at a time.

`timescale 1ns/100ps

`include "dmem_defines.svh"

module dmem_top
	import dmem_pkg::*;
(
	input	logic							clock,
	input	logic							reset,
	// APB slave
	input	logic							psel,
	input	logic							penable,
	input	logic							pwrite,
	input	logic [`DMEM_APB_ADDR_WIDTH-1:0]	paddr,
	input	data_t							pwdata,
	output	data_t							prdata,
	output	logic							pready,
	output	logic							pslverr,
	// Store stream
	input	logic							st_valid,
	input	data_t							st_data,
	output	logic							st_ready,
	// Load stream
	output	logic							ld_valid,
	output	data_t							ld_data,
	input	logic							ld_ready
);

	dmem_desc_if	st_desc ();
	dmem_desc_if	ld_desc ();
	dmem_access_if	st_acc ();
	dmem_access_if	ld_acc ();

	//////////////////////////////////////////////////
	// Configuration
	//////////////////////////////////////////////////

	dmem_cfg_decode cfg_decode_i (
		.clock		(clock),
		.reset		(reset),
		.psel		(psel),
		.penable	(penable),
		.pwrite		(pwrite),
		.paddr		(paddr),
		.pwdata		(pwdata),
		.prdata		(prdata),
		.pready		(pready),
		.pslverr	(pslverr),
		.st_desc	(st_desc),
		.ld_desc	(ld_desc)
	);

	//////////////////////////////////////////////////
	// Address generators
	//////////////////////////////////////////////////

	dmem_agu agu_st (
		.clock	(clock),
		.reset	(reset),
		.desc	(st_desc),
		.acc	(st_acc)
	);

	dmem_agu agu_ld (
		.clock	(clock),
		.reset	(reset),
		.desc	(ld_desc),
		.acc	(ld_acc)
	);

	//////////////////////////////////////////////////
	// Memory
	//////////////////////////////////////////////////

	dmem_bank bank_i (
		.clock		(clock),
		.reset		(reset),
		.st_acc		(st_acc),
		.ld_acc		(ld_acc),
		.st_valid	(st_valid),
		.st_data	(st_data),
		.ld_ready	(ld_ready),
		.st_ready	(st_ready),
		.ld_valid	(ld_valid),
		.ld_data	(ld_data),
		.st_busy	(st_desc.busy)	// Store ready follows busy
	);

endmodule

// ==== src.f ====
+incdir+rtl
rtl/dmem_pkg.sv
rtl/dmem_if.sv
rtl/dmem_cfg_decode.sv
rtl/dmem_agu.sv
rtl/dmem_bank.sv
rtl/dmem_top.sv
verification/dmem_properties.sv
verification/dmem_tb.sv

// ==== verification/dmem_properties.sv ====
// Concurrent checks on the data memory top-level ports.
// Bound into dmem_top and sampled on the rising clock.

`timescale 1ns/100ps

module dmem_properties
	import dmem_pkg::*;
(
	input	logic	clock,
	input	logic	reset,
	input	logic	psel,
	input	logic	penable,
	input	logic	pready,
	input	logic	pslverr,
	input	logic	st_ready,
	input	logic	ld_valid,
	input	logic	ld_ready,
	input	data_t	ld_data
);

	// Zero wait states
	pready_high: assert property (@(posedge clock) disable iff (reset) pready)
		else $error("pready went low");

	pslverr_in_access: assert property (@(posedge clock) disable iff (reset)
			pslverr |-> (psel && penable))
		else $error("pslverr outside an APB access phase");

	// Stalled load word must not move
	load_stable: assert property (@(posedge clock) disable iff (reset)
			(ld_valid && !ld_ready) |=> (ld_valid && $stable(ld_data)))
		else $error("load word changed or dropped while stalled");

	store_idle_after_reset: assert property (@(posedge clock) reset |=> !st_ready)
		else $error("st_ready high in the cycle after reset");

endmodule

bind dmem_top dmem_properties props_i (
	.clock		(clock),
	.reset		(reset),
	.psel		(psel),
	.penable	(penable),
	.pready		(pready),
	.pslverr	(pslverr),
	.st_ready	(st_ready),
	.ld_valid	(ld_valid),
	.ld_ready	(ld_ready),
	.ld_data	(ld_data)
);

// ==== verification/dmem_tb.sv ====
// Directed testbench for the strided data memory.
// Inputs change 1 ns after the rising edge; outputs are sampled on the
// falling edge. The reference memory only knows words stored here, so
// loads must walk addresses written earlier in the run.

`timescale 1ns/100ps

`include "dmem_defines.svh"

module dmem_tb
	import dmem_pkg::*;
();

	typedef logic [`DMEM_APB_ADDR_WIDTH-1:0] apb_addr_t;

	localparam int			CLOCK_PERIOD	= 10;
	localparam logic [31:0]	LCG_SEED		= 32'd81;
	localparam int			TOTAL_WORDS		= 20 + 20 + 20 + 10 + 12 + 12;
	localparam int			TIMEOUT_CYCLES	= TOTAL_WORDS * 20 + 1000;
	localparam apb_addr_t	OFF_ST_BASE		= 5'h00;
	localparam apb_addr_t	OFF_LD_BASE		= 5'h0C;
	localparam apb_addr_t	OFF_ST_LENGTH	= 5'h04;
	localparam apb_addr_t	OFF_CONTROL		= 5'h18;
	localparam apb_addr_t	OFF_STATUS		= 5'h1C;

	logic		clock;
	logic		reset;
	logic		psel, penable, pwrite, pready, pslverr;
	apb_addr_t	paddr;
	data_t		pwdata, prdata;
	logic		st_valid, st_ready, ld_valid, ld_ready;
	data_t		st_data, ld_data;

	logic [31:0]	lcg_state = LCG_SEED;
	data_t			ref_mem [`DMEM_DEPTH];		// Mirrors every accepted store

	dmem_top dmem_top_i (.*);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLOCK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("Test failures found");
		$fatal(1);
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Word k of a descriptor sits at base + k * stride, modulo depth
	function automatic address_t word_addr(address_t base, stride_t stride, int k);
		return address_t'(int'(base) + k * int'(stride));
	endfunction

	task automatic check_value(input string test_name, input data_t expected,
			input data_t actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s: expected %h, actual %h", test_name, expected, actual);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("ERROR: %s", what);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// Setup and access phase; entered and left 1 ns after a rising edge
	task automatic apb_access(input logic write, input apb_addr_t addr, input data_t wdata,
			output data_t rdata, output logic err);
		psel	= 1'b1;
		penable	= 1'b0;
		pwrite	= write;
		paddr	= addr;
		pwdata	= wdata;
		@(posedge clock);
		#1 penable = 1'b1;
		@(negedge clock);
		rdata	= prdata;		// Access phase, settled
		err		= pslverr;
		@(posedge clock);
		#1 psel = 1'b0;
		penable	= 1'b0;
		pwrite	= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input data_t data);
		data_t	unused;
		logic	err;
		apb_access(1'b1, addr, data, unused, err);
		check_true(!err, "pslverr raised on a write to a mapped offset");
	endtask

	task automatic apb_read(input apb_addr_t addr, output data_t data);
		logic	err;
		apb_access(1'b0, addr, '0, data, err);
		check_true(!err, "pslverr raised on a read of a mapped offset");
	endtask

	task automatic program_channel(input logic is_load, input address_t base,
			input length_t length, input stride_t stride);
		apb_addr_t	first;
		first = is_load ? OFF_LD_BASE : OFF_ST_BASE;
		apb_write(first, data_t'(base));
		apb_write(first + apb_addr_t'(4), data_t'(length));
		apb_write(first + apb_addr_t'(8), data_t'(stride));
	endtask

	task automatic store_words(input address_t base, input length_t length,
			input stride_t stride);
		data_t	word;
		logic	accepted;
		int		k;
		k			= 0;
		word		= lcg_next();
		st_valid	= 1'b1;
		st_data		= word;
		while (k < int'(length)) begin
			@(negedge clock);
			accepted = st_ready;		// Transfer happens at the next edge
			@(posedge clock);
			#1;
			if (accepted) begin
				ref_mem[word_addr(base, stride, k)] = word;
				k++;
				word	= lcg_next();
				st_data	= word;
			end
		end
		st_valid = 1'b0;
	endtask

	task automatic load_words(input string test_name, input address_t base,
			input length_t length, input stride_t stride, input logic random_ready);
		data_t	rnd;
		int		k;
		k = 0;
		while (k < int'(length)) begin
			rnd			= lcg_next();
			ld_ready	= random_ready ? rnd[16] : 1'b1;
			@(negedge clock);
			if (ld_valid && ld_ready) begin
				check_value(test_name, ref_mem[word_addr(base, stride, k)], ld_data);
				k++;
			end
			@(posedge clock);
			#1;
		end
		ld_ready = 1'b0;
		@(negedge clock);
		check_true(!ld_valid, "load stream presented a word beyond the descriptor length");
		@(posedge clock);
		#1;
	endtask

	task automatic check_idle(input string test_name);
		data_t	status;
		apb_read(OFF_STATUS, status);
		check_value(test_name, 32'h0, status);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_registers();
		data_t	values [6];
		data_t	rdata;
		logic	err;
		for (int i = 0; i < 6; i++) begin
			values[i] = lcg_next() & 32'hFF;		// Registers are 8 bits wide
			apb_write(apb_addr_t'(i * 4), values[i]);
		end
		for (int i = 0; i < 6; i++) begin
			apb_read(apb_addr_t'(i * 4), rdata);
			check_value("registers readback", values[i], rdata);
		end
		apb_read(OFF_CONTROL, rdata);
		check_value("registers control", 32'h0, rdata);
		apb_access(1'b0, 5'h06, '0, rdata, err);
		check_true(err, "pslverr not raised on a read of unmapped offset 0x06");
		apb_access(1'b1, 5'h11, 32'h5, rdata, err);
		check_true(err, "pslverr not raised on a write to unmapped offset 0x11");
	endtask

	task automatic test_strided();
		program_channel(1'b0, 8'h10, 8'd20, 8'd5);
		apb_write(OFF_CONTROL, 32'h1);
		store_words(8'h10, 8'd20, 8'd5);
		program_channel(1'b1, 8'h10, 8'd20, 8'd5);
		apb_write(OFF_CONTROL, 32'h2);
		load_words("strided load", 8'h10, 8'd20, 8'd5, 1'b0);
		check_idle("strided status");
	endtask

	task automatic test_backpressure();
		apb_write(OFF_CONTROL, 32'h2);		// Load descriptor still programmed
		load_words("back-pressure load", 8'h10, 8'd20, 8'd5, 1'b1);
		check_idle("back-pressure status");
	endtask

	task automatic test_busy_restart();
		data_t	status;
		program_channel(1'b0, 8'h80, 8'd10, 8'd1);
		apb_write(OFF_CONTROL, 32'h1);
		apb_read(OFF_STATUS, status);
		check_value("busy status", 32'h1, status);
		apb_write(OFF_ST_LENGTH, 32'd3);
		apb_write(OFF_CONTROL, 32'h1);		// Dropped, store is busy
		store_words(8'h80, 8'd10, 8'd1);
		st_valid = 1'b1;
		repeat (4) begin
			@(negedge clock);
			check_true(!st_ready, "store accepted a word beyond the first length");
			@(posedge clock);
			#1;
		end
		st_valid = 1'b0;
		check_idle("restart status");
		apb_write(OFF_ST_LENGTH, 32'd0);
		apb_write(OFF_CONTROL, 32'h1);
		repeat (3) begin
			@(negedge clock);
			check_true(!st_ready, "store became ready after a start with length 0");
			@(posedge clock);
			#1;
		end
		check_idle("zero length status");
	endtask

	task automatic test_wrap();
		program_channel(1'b0, 8'hFD, 8'd12, 8'd3);
		apb_write(OFF_CONTROL, 32'h1);
		store_words(8'hFD, 8'd12, 8'd3);
		program_channel(1'b1, 8'hFD, 8'd12, 8'd3);
		apb_write(OFF_CONTROL, 32'h2);
		load_words("wrap load", 8'hFD, 8'd12, 8'd3, 1'b0);
		check_idle("wrap status");
	endtask

	initial begin
		reset		= 1'b1;
		psel		= 1'b0;
		penable		= 1'b0;
		pwrite		= 1'b0;
		paddr		= '0;
		pwdata		= '0;
		st_valid	= 1'b0;
		st_data		= '0;
		ld_ready	= 1'b0;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		test_registers();
		test_strided();
		test_backpressure();
		test_busy_restart();
		test_wrap();
		$display("All tests passed!");
		$finish;
	end

endmodule
